/* Bender.yml */
package:
  name: exu

sources:
  - include_dirs:
      - common
    files:
      - common/exu_pkg.sv
      - common/muldiv_if.sv
      - muldiv/seq_multiplier.sv
      - muldiv/seq_divider.sv
      - source/alu_core.sv
      - source/exu_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/exu_checker.sv
      - test/exu_tb.sv

/* common/exu_config.svh */
`ifndef EXU_CONFIG_SVH
`define EXU_CONFIG_SVH

// datapath width
`define XLEN 64

// shift amount taken from the low bits of operand b
`define SHAMT_W 6

// multiplier bits retired per cycle, XLEN / this = multiply latency
`define MUL_STEP_BITS 2

`endif

/* common/exu_pkg.sv */
package exu_pkg;

    // execute unit operations
    typedef enum logic [4:0] {
        ADD,
        SUB,
        PASS_A,
        PASS_B,
        XOR,
        OR,
        AND,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        EQ,
        GE,
        GEU,
        // multi-cycle, handled by the sequential units
        MUL,
        DIV,
        DIVU,
        REM,
        REMU
    } alu_op_e;

    // first operand source
    typedef enum logic {
        SRC_A_PC,
        SRC_A_RS1
    } src_a_e;

    // second operand source
    typedef enum logic [1:0] {
        SRC_B_IMM,
        SRC_B_RS2,
        SRC_B_CSR
    } src_b_e;

    // operation code sent to a sequential unit
    typedef enum logic [2:0] {
        MD_MUL,
        MD_DIV,
        MD_DIVU,
        MD_REM,
        MD_REMU
    } md_op_e;

    // stall controller for multi-cycle ops
    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE
    } issue_state_e;

endpackage

/* common/muldiv_if.sv */
`timescale 1ns/1ps
`include "exu_config.svh"

interface muldiv_if;

    logic             start;
    logic             abort;
    exu_pkg::md_op_e  op;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic             done;
    logic [`XLEN-1:0] result;

    // alu core side
    modport requester (
        output start, abort, op, a, b,
        input  done, result
    );

    // sequential unit side
    modport unit (
        input  start, abort, op, a, b,
        output done, result
    );

endinterface

/* flist.f */
+incdir+common
common/exu_pkg.sv
common/muldiv_if.sv
muldiv/seq_multiplier.sv
muldiv/seq_divider.sv
source/alu_core.sv
source/exu_top.sv
test/exu_checker.sv
test/exu_tb.sv

/* muldiv/seq_divider.sv */
`timescale 1ns/1ps
`include "exu_config.svh"

module seq_divider (
    input  logic    clk,
    input  logic    arst_n,
    muldiv_if.unit  bus
);

    localparam int CNT_W = $clog2(`XLEN + 1);
    localparam logic [`XLEN-1:0] MIN_VAL = {1'b1, {(`XLEN-1){1'b0}}};

    logic             busy;
    logic [CNT_W-1:0] count;
    logic             fix_cycle;
    exu_pkg::md_op_e  op_q;
    logic             is_signed;
    logic             neg_a;
    logic             neg_b;
    logic [`XLEN-1:0] dividend;
    logic [`XLEN-1:0] divisor;
    logic [`XLEN-1:0] quo;
    logic [`XLEN-1:0] rem;
    logic             neg_q;
    logic             neg_r;
    logic             div_zero;
    logic             ovf;
    logic [`XLEN:0]   rem_shift;
    logic [`XLEN:0]   diff;
    logic [`XLEN-1:0] q_fix;
    logic [`XLEN-1:0] r_fix;

    assign is_signed = bus.op inside {exu_pkg::MD_DIV, exu_pkg::MD_REM};
    assign neg_a = is_signed && bus.a[`XLEN-1];
    assign neg_b = is_signed && bus.b[`XLEN-1];

    // one restoring step, next dividend bit comes from the quotient shifter
    assign rem_shift = {rem, quo[`XLEN-1]};
    assign diff = rem_shift - {1'b0, divisor};

    assign fix_cycle = (count == CNT_W'(`XLEN));

    always_comb begin
        if (div_zero) begin
            q_fix = '1;
            r_fix = dividend;
        end else if (ovf) begin
            q_fix = dividend;
            r_fix = '0;
        end else begin
            q_fix = neg_q ? -quo : quo;
            r_fix = neg_r ? -rem : rem;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            count <= '0;
            bus.done <= 1'b0;
        end else begin
            bus.done <= 1'b0;
            if (bus.abort) begin
                busy <= 1'b0;
                count <= '0;
            end else if (!busy) begin
                if (bus.start) begin
                    busy <= 1'b1;
                    count <= '0;
                end
            end else if (fix_cycle) begin
                busy <= 1'b0;
                bus.done <= 1'b1;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && bus.start) begin
            op_q <= bus.op;
            dividend <= bus.a;
            divisor <= neg_b ? -bus.b : bus.b;
            quo <= neg_a ? -bus.a : bus.a;
            rem <= '0;
            neg_q <= neg_a ^ neg_b;
            // remainder takes the dividend's sign
            neg_r <= neg_a;
            div_zero <= (bus.b == '0);
            ovf <= is_signed && (bus.a == MIN_VAL) && (bus.b == '1);
        end else if (busy) begin
            if (fix_cycle) begin
                if ((op_q == exu_pkg::MD_REM) || (op_q == exu_pkg::MD_REMU)) begin
                    bus.result <= r_fix;
                end else begin
                    bus.result <= q_fix;
                end
            end else if (!diff[`XLEN]) begin
                rem <= diff[`XLEN-1:0];
                quo <= {quo[`XLEN-2:0], 1'b1};
            end else begin
                rem <= rem_shift[`XLEN-1:0];
                quo <= {quo[`XLEN-2:0], 1'b0};
            end
        end
    end

endmodule

/* muldiv/seq_multiplier.sv */
`timescale 1ns/1ps
`include "exu_config.svh"

module seq_multiplier (
    input  logic    clk,
    input  logic    arst_n,
    muldiv_if.unit  bus
);

    localparam int STEPS = `XLEN / `MUL_STEP_BITS;
    localparam int CNT_W = $clog2(STEPS);

    logic             busy;
    logic [CNT_W-1:0] step;
    logic [`XLEN-1:0] mcand;
    logic [`XLEN-1:0] mplier;
    logic [`XLEN-1:0] acc;
    logic [`XLEN-1:0] partial;
    logic [`XLEN-1:0] acc_next;
    logic             last_step;

    // shifted copies of the multiplicand for the current digit
    always_comb begin
        partial = '0;
        for (int i = 0; i < `MUL_STEP_BITS; i++) begin
            if (mplier[i]) begin
                partial = partial + (mcand << i);
            end
        end
        acc_next = acc + partial;
    end

    assign last_step = (step == CNT_W'(STEPS - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            step <= '0;
            bus.done <= 1'b0;
        end else begin
            bus.done <= 1'b0;
            if (bus.abort) begin
                busy <= 1'b0;
                step <= '0;
            end else if (!busy) begin
                if (bus.start) begin
                    busy <= 1'b1;
                    step <= '0;
                end
            end else begin
                step <= step + 1'b1;
                if (last_step) begin
                    busy <= 1'b0;
                    bus.done <= 1'b1;
                end
            end
        end
    end

    // operands and accumulator
    always_ff @(posedge clk) begin
        if (!busy && bus.start) begin
            mcand <= bus.a;
            mplier <= bus.b;
            acc <= '0;
        end else if (busy) begin
            mcand <= mcand << `MUL_STEP_BITS;
            mplier <= mplier >> `MUL_STEP_BITS;
            acc <= acc_next;
            if (last_step) begin
                bus.result <= acc_next;
            end
        end
    end

endmodule

/* source/alu_core.sv */
`timescale 1ns/1ps
`include "exu_config.svh"

module alu_core (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  flush,
    input  logic [`XLEN-1:0]      pc,
    input  logic [`XLEN-1:0]      rs1,
    input  logic [`XLEN-1:0]      rs2,
    input  logic [`XLEN-1:0]      csr,
    input  logic [`XLEN-1:0]      imm,
    input  exu_pkg::alu_op_e      operate,
    input  exu_pkg::src_a_e       sel_a,
    input  exu_pkg::src_b_e       sel_b,
    input  logic                  word_mode,
    output logic [`XLEN-1:0]      res,
    output logic                  alu_wait,
    muldiv_if.requester           mul_bus,
    muldiv_if.requester           div_bus
);

    logic [`XLEN-1:0]      a;
    logic [`XLEN-1:0]      b;
    logic [`SHAMT_W-1:0]   shamt;
    logic                  is_div;
    logic                  is_muldiv;
    logic                  issue;
    logic                  use_div;
    logic                  unit_done;
    logic [`XLEN-1:0]      unit_result;
    exu_pkg::md_op_e       md_op;
    exu_pkg::issue_state_e state;

    // widen a compare flag to a full result
    function automatic logic [`XLEN-1:0] flag(input logic f);
        flag = {{(`XLEN-1){1'b0}}, f};
    endfunction

    // operand a, rs1 may be cut to its low word
    always_comb begin
        if (sel_a == exu_pkg::SRC_A_RS1) begin
            a = word_mode ? {{(`XLEN-32){1'b0}}, rs1[31:0]} : rs1;
        end else begin
            a = pc;
        end
    end

    always_comb begin
        case (sel_b)
            exu_pkg::SRC_B_RS2: b = rs2;
            exu_pkg::SRC_B_CSR: b = csr;
            default:            b = imm;
        endcase
    end

    assign shamt = b[`SHAMT_W-1:0];

    assign is_div = operate inside {exu_pkg::DIV, exu_pkg::DIVU, exu_pkg::REM, exu_pkg::REMU};
    assign is_muldiv = is_div || (operate == exu_pkg::MUL);

    always_comb begin
        case (operate)
            exu_pkg::DIV:  md_op = exu_pkg::MD_DIV;
            exu_pkg::DIVU: md_op = exu_pkg::MD_DIVU;
            exu_pkg::REM:  md_op = exu_pkg::MD_REM;
            exu_pkg::REMU: md_op = exu_pkg::MD_REMU;
            default:       md_op = exu_pkg::MD_MUL;
        endcase
    end

    // a new run only starts from idle out of reset, and never under flush
    assign issue = arst_n && (state == exu_pkg::IDLE) && is_muldiv && !flush;
    assign alu_wait = issue || (state == exu_pkg::BUSY);

    assign mul_bus.start = issue && !is_div;
    assign mul_bus.abort = (state == exu_pkg::BUSY) && flush && !use_div;
    assign mul_bus.op = md_op;
    assign mul_bus.a = a;
    assign mul_bus.b = b;

    assign div_bus.start = issue && is_div;
    assign div_bus.abort = (state == exu_pkg::BUSY) && flush && use_div;
    assign div_bus.op = md_op;
    assign div_bus.a = a;
    assign div_bus.b = b;

    assign unit_done = use_div ? div_bus.done : mul_bus.done;
    assign unit_result = use_div ? div_bus.result : mul_bus.result;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= exu_pkg::IDLE;
            use_div <= 1'b0;
        end else begin
            case (state)
                exu_pkg::IDLE: begin
                    if (issue) begin
                        state <= exu_pkg::BUSY;
                        use_div <= is_div;
                    end
                end
                exu_pkg::BUSY: begin
                    if (flush) begin
                        state <= exu_pkg::IDLE;
                    end else if (unit_done) begin
                        state <= exu_pkg::DONE;
                    end
                end
                // one cycle, so a repeated muldiv op restarts
                default: state <= exu_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res <= '0;
        end else if (is_muldiv) begin
            // flush drops a result arriving in the same cycle
            if ((state == exu_pkg::BUSY) && unit_done && !flush) begin
                res <= unit_result;
            end
        end else begin
            case (operate)
                exu_pkg::ADD:    res <= a + b;
                exu_pkg::SUB:    res <= a - b;
                exu_pkg::PASS_A: res <= a;
                exu_pkg::PASS_B: res <= b;
                exu_pkg::XOR:    res <= a ^ b;
                exu_pkg::OR:     res <= a | b;
                exu_pkg::AND:    res <= a & b;
                exu_pkg::SLL:    res <= a << shamt;
                exu_pkg::SRL:    res <= a >> shamt;
                exu_pkg::SRA: begin
                    // word sra shifts the low half, result zero-extended
                    if (word_mode) begin
                        res <= {{(`XLEN-32){1'b0}}, $signed(a[31:0]) >>> shamt};
                    end else begin
                        res <= $signed(a) >>> shamt;
                    end
                end
                exu_pkg::SLT:    res <= flag($signed(a) < $signed(b));
                exu_pkg::SLTU:   res <= flag(a < b);
                exu_pkg::EQ:     res <= flag(a == b);
                exu_pkg::GE:     res <= flag($signed(a) >= $signed(b));
                exu_pkg::GEU:    res <= flag(a >= b);
                default:         res <= res;
            endcase
        end
    end

endmodule

/* source/exu_top.sv */
`timescale 1ns/1ps
`include "exu_config.svh"

module exu_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  flush,
    input  logic [`XLEN-1:0]      pc,
    input  exu_pkg::alu_op_e      operate,
    input  logic [`XLEN-1:0]      rs1,
    input  logic [`XLEN-1:0]      rs2,
    input  logic [`XLEN-1:0]      csr,
    input  logic [`XLEN-1:0]      imm,
    input  exu_pkg::src_a_e       sel_a,
    input  exu_pkg::src_b_e       sel_b,
    input  logic                  word_mode,
    output logic [`XLEN-1:0]      res,
    output logic                  alu_wait
);

    // one bus per sequential unit
    muldiv_if mul_bus ();
    muldiv_if div_bus ();

    alu_core u_core (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush),
        .pc        (pc),
        .rs1       (rs1),
        .rs2       (rs2),
        .csr       (csr),
        .imm       (imm),
        .operate   (operate),
        .sel_a     (sel_a),
        .sel_b     (sel_b),
        .word_mode (word_mode),
        .res       (res),
        .alu_wait  (alu_wait),
        .mul_bus   (mul_bus.requester),
        .div_bus   (div_bus.requester)
    );

    seq_multiplier u_mul (
        .clk    (clk),
        .arst_n (arst_n),
        .bus    (mul_bus.unit)
    );

    seq_divider u_div (
        .clk    (clk),
        .arst_n (arst_n),
        .bus    (div_bus.unit)
    );

endmodule

/* test/exu_checker.sv */
`timescale 1ns/1ps

module exu_checker (
    input logic                  clk,
    input logic                  arst_n,
    input logic                  flush,
    input exu_pkg::alu_op_e      operate,
    input exu_pkg::issue_state_e state,
    input logic                  alu_wait
);

    // count of failed assertions
    int   fail_count = 0;
    logic is_muldiv;
    logic busy;

    assign is_muldiv = operate inside {exu_pkg::MUL, exu_pkg::DIV, exu_pkg::DIVU,
                                       exu_pkg::REM, exu_pkg::REMU};
    assign busy = (state == exu_pkg::BUSY);

    reset_quiet: assert property (@(posedge clk) !arst_n |-> !alu_wait)
        else begin
            $error("alu_wait high during reset");
            fail_count++;
        end

    single_no_wait: assert property (@(posedge clk) disable iff (!arst_n)
        (!is_muldiv && !busy) |-> !alu_wait)
        else begin
            $error("alu_wait high for a single-cycle op while not busy");
            fail_count++;
        end

    // divider is the slow one, about 66 cycles
    wait_bounded: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(alu_wait) |-> ##[1:80] !alu_wait)
        else begin
            $error("alu_wait stayed high for more than 80 cycles");
            fail_count++;
        end

    flush_drops_wait: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> !alu_wait)
        else begin
            $error("alu_wait high on the cycle after flush");
            fail_count++;
        end

endmodule

bind exu_top exu_checker u_checker (
    .clk      (clk),
    .arst_n   (arst_n),
    .flush    (flush),
    .operate  (operate),
    .state    (u_core.state),
    .alu_wait (alu_wait)
);

/* test/exu_tb.sv */
`timescale 1ns/1ps
`include "exu_config.svh"

module exu_tb;

    localparam int WAIT_LIMIT = 200;
    localparam logic [`XLEN-1:0] MIN_VAL = {1'b1, {(`XLEN-1){1'b0}}};

    logic                  clk;
    logic                  arst_n;
    logic                  flush;
    logic [`XLEN-1:0]      pc;
    logic [`XLEN-1:0]      rs1;
    logic [`XLEN-1:0]      rs2;
    logic [`XLEN-1:0]      csr;
    logic [`XLEN-1:0]      imm;
    exu_pkg::alu_op_e      operate;
    exu_pkg::src_a_e       sel_a;
    exu_pkg::src_b_e       sel_b;
    logic                  word_mode;
    logic [`XLEN-1:0]      res;
    logic                  alu_wait;
    integer                seed = 9339;
    int                    errors = 0;
    logic [`XLEN-1:0]      edge_vals [4];

    exu_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [`XLEN-1:0] rand64();
        rand64 = {$random(seed), $random(seed)};
    endfunction

    task automatic check(input string name, input logic [`XLEN-1:0] exp, act);
        assert (act === exp) else begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic finish_run();
        int total;
        // give a late assertion time to land
        repeat (2) @(posedge clk);
        total = errors + DUT.u_checker.fail_count;
        $display("errors: %0d in checks, %0d in assertions", errors, DUT.u_checker.fail_count);
        if (total == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    // expected result from the instruction rules
    task automatic reference(input exu_pkg::alu_op_e op, input logic wm,
                             input logic [`XLEN-1:0] a, b, output logic [`XLEN-1:0] exp);
        logic [5:0]  sh;
        logic [31:0] w;
        logic        sgn;
        logic        quot;
        sh = b[5:0];
        sgn = op inside {exu_pkg::DIV, exu_pkg::REM};
        quot = op inside {exu_pkg::DIV, exu_pkg::DIVU};
        case (op)
            exu_pkg::ADD:    exp = a + b;
            exu_pkg::SUB:    exp = a - b;
            exu_pkg::PASS_A: exp = a;
            exu_pkg::PASS_B: exp = b;
            exu_pkg::XOR:    exp = a ^ b;
            exu_pkg::OR:     exp = a | b;
            exu_pkg::AND:    exp = a & b;
            exu_pkg::SLL:    exp = a << sh;
            exu_pkg::SRL:    exp = a >> sh;
            exu_pkg::SRA: begin
                // logical shift, vacated bits filled with the sign
                if (wm) begin
                    w = (a[31:0] >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
                    exp = {{(`XLEN-32){1'b0}}, w};
                end else begin
                    exp = (a >> sh) | (a[`XLEN-1] ? ~({`XLEN{1'b1}} >> sh) : '0);
                end
            end
            exu_pkg::SLT:    exp = ($signed(a) < $signed(b)) ? 1 : 0;
            exu_pkg::SLTU:   exp = (a < b) ? 1 : 0;
            exu_pkg::EQ:     exp = (a == b) ? 1 : 0;
            exu_pkg::GE:     exp = ($signed(a) >= $signed(b)) ? 1 : 0;
            exu_pkg::GEU:    exp = (a >= b) ? 1 : 0;
            exu_pkg::MUL:    exp = a * b;
            default: begin
                if (b == '0) begin
                    exp = quot ? '1 : a;
                end else if (sgn && (a == MIN_VAL) && (b == '1)) begin
                    exp = quot ? a : '0;
                end else if (sgn) begin
                    exp = quot ? $signed(a) / $signed(b) : $signed(a) % $signed(b);
                end else begin
                    exp = quot ? a / b : a % b;
                end
            end
        endcase
    endtask

    task automatic present(input exu_pkg::alu_op_e op, input exu_pkg::src_a_e sa,
                           input exu_pkg::src_b_e sb, input logic wm,
                           input logic [`XLEN-1:0] x, y, output logic [`XLEN-1:0] exp);
        logic [`XLEN-1:0] p;
        logic [`XLEN-1:0] c;
        logic [`XLEN-1:0] im;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        p = rand64();
        c = rand64();
        im = rand64();
        a = (sa == exu_pkg::SRC_A_PC) ? p : (wm ? {{(`XLEN-32){1'b0}}, x[31:0]} : x);
        b = (sb == exu_pkg::SRC_B_RS2) ? y : ((sb == exu_pkg::SRC_B_CSR) ? c : im);
        reference(op, wm, a, b, exp);
        @(posedge clk);
        operate <= op;
        sel_a <= sa;
        sel_b <= sb;
        word_mode <= wm;
        pc <= p;
        rs1 <= x;
        rs2 <= y;
        csr <= c;
        imm <= im;
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (alu_wait && (cycles < WAIT_LIMIT));
        if (alu_wait) begin
            $display("timeout: alu_wait still high after %0d cycles", WAIT_LIMIT);
            errors++;
            finish_run();
        end
    endtask

    task automatic run_op(input exu_pkg::alu_op_e op, input exu_pkg::src_a_e sa,
                          input exu_pkg::src_b_e sb, input logic wm,
                          input logic [`XLEN-1:0] x, y);
        logic [`XLEN-1:0] exp;
        present(op, sa, sb, wm, x, y, exp);
        if (op inside {exu_pkg::MUL, exu_pkg::DIV, exu_pkg::DIVU, exu_pkg::REM, exu_pkg::REMU}) begin
            wait_ready();
        end else begin
            @(posedge clk);
            @(negedge clk);
        end
        check("res", exp, res);
    endtask

    task automatic run_md(input exu_pkg::alu_op_e op, input logic [`XLEN-1:0] x, y);
        run_op(op, exu_pkg::SRC_A_RS1, exu_pkg::SRC_B_RS2, 1'b0, x, y);
    endtask

    // flush partway through, then a clean run of the same op
    task automatic abort_run(input exu_pkg::alu_op_e op);
        logic [`XLEN-1:0] exp;
        logic [`XLEN-1:0] held;
        present(op, exu_pkg::SRC_A_RS1, exu_pkg::SRC_B_RS2, 1'b0, rand64(), rand64(), exp);
        @(negedge clk);
        held = res;
        repeat (10) @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        operate <= exu_pkg::PASS_A;
        @(negedge clk);
        check("alu_wait", '0, alu_wait);
        check("res", held, res);
        run_md(op, rand64(), rand64());
    endtask

    initial begin
        exu_pkg::alu_op_e md;
        edge_vals[0] = '0;
        edge_vals[1] = 1;
        edge_vals[2] = '1;
        edge_vals[3] = MIN_VAL;
        arst_n <= 1'b0;
        flush <= 1'b0;
        pc <= '0;
        rs1 <= '0;
        rs2 <= '0;
        csr <= '0;
        imm <= '0;
        // a muldiv op held through reset must not raise alu_wait
        operate <= exu_pkg::MUL;
        sel_a <= exu_pkg::SRC_A_RS1;
        sel_b <= exu_pkg::SRC_B_RS2;
        word_mode <= 1'b0;
        repeat (3) @(posedge clk);
        operate <= exu_pkg::ADD;
        arst_n <= 1'b1;
        @(negedge clk);
        check("res", '0, res);
        check("alu_wait", '0, alu_wait);

        for (int op = 0; op < int'(exu_pkg::MUL); op++) begin
            for (int sa = 0; sa < 2; sa++) begin
                for (int sb = 0; sb < 3; sb++) begin
                    run_op(exu_pkg::alu_op_e'(op), exu_pkg::src_a_e'(sa),
                           exu_pkg::src_b_e'(sb), 1'($random(seed)), rand64(), rand64());
                end
            end
        end

        // shift edges, negative values so sra fills with ones
        for (int amt = 0; amt < 64; amt += 63) begin
            run_md(exu_pkg::SLL, rand64(), amt);
            run_md(exu_pkg::SRL, rand64() | MIN_VAL, amt);
            run_md(exu_pkg::SRA, rand64() | MIN_VAL, amt);
            run_op(exu_pkg::SRA, exu_pkg::SRC_A_RS1, exu_pkg::SRC_B_RS2, 1'b1,
                   rand64() | 64'h8000_0000, amt);
        end
        run_op(exu_pkg::PASS_A, exu_pkg::SRC_A_RS1, exu_pkg::SRC_B_RS2, 1'b1, rand64(), 0);

        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                run_md(exu_pkg::MUL, edge_vals[i], edge_vals[j]);
            end
        end
        repeat (4) run_md(exu_pkg::MUL, rand64(), rand64());

        for (int op = int'(exu_pkg::DIV); op <= int'(exu_pkg::REMU); op++) begin
            md = exu_pkg::alu_op_e'(op);
            repeat (4) run_md(md, rand64(), rand64());
            run_md(md, rand64(), rand64() & 64'hff);
            run_md(md, rand64(), '0);
            run_md(md, MIN_VAL, '1);
        end

        abort_run(exu_pkg::MUL);
        abort_run(exu_pkg::DIV);

        // back to back, each restart through DONE
        run_md(exu_pkg::MUL, rand64(), rand64());
        run_md(exu_pkg::MUL, rand64(), rand64());
        run_md(exu_pkg::REMU, rand64(), rand64());
        finish_run();
    end

endmodule
